// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_hlane
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "FAIL"; \
		exit 1; \
	elif grep -q "Test completed successfully" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL: no result in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== rtl/alu16.sv ====
`timescale 1ns/10ps

module alu16 (
	input  hlane_pkg::instruction_t ir_i,
	input  hlane_pkg::half_value_t  a_i,
	input  hlane_pkg::half_value_t  b_i,
	input  hlane_pkg::half_value_t  imm_i,
	output hlane_pkg::half_value_t  o_o
);

	logic                   sgn, xz, vz, inf, xinf, snan, qnan; // fields of a
	logic [15:0]            fcmp;   // a vs b
	logic [15:0]            fcmpi;  // a vs imm
	hlane_pkg::half_value_t fclass;
	logic [4:0]             cntlz;  // 0..16

	// compare results go out as 0 or 1
	function automatic hlane_pkg::half_value_t flag(input logic c);
		return {15'd0, c};
	endfunction

	fp_decomp16 decomp_inst (
		.i_i   (a_i),
		.sgn_o (sgn),
		.xz_o  (xz),
		.vz_o  (vz),
		.inf_o (inf),
		.xinf_o(xinf),
		.snan_o(snan),
		.qnan_o(qnan)
	);

	fp_compare16 cmp_reg_inst (.a_i(a_i), .b_i(b_i), .o_o(fcmp));
	fp_compare16 cmp_imm_inst (.a_i(a_i), .b_i(imm_i), .o_o(fcmpi));

	// ============================================================
	// unary helpers
	// ============================================================
	always_comb begin
		cntlz = 5'd16; // all zero input
		for (int i = 0; i < 16; i++) begin
			if (a_i[i])
				cntlz = 5'(15 - i); // highest set bit wins, scanned last
		end
	end

	always_comb begin
		fclass     = '0;
		fclass[0]  = sgn & inf;         // -inf
		fclass[1]  = sgn;               // negative
		fclass[2]  = sgn & xz & ~vz;    // -subnormal
		fclass[3]  = sgn & vz;          // -0
		fclass[4]  = ~sgn & vz;         // +0
		fclass[5]  = ~sgn & xz & ~vz;   // +subnormal
		fclass[6]  = ~sgn;              // positive
		fclass[7]  = ~sgn & inf;        // +inf
		fclass[8]  = snan;
		fclass[9]  = qnan;
		fclass[15] = sgn;
	end

	// ============================================================
	// opcode -> func -> unary selector
	// ============================================================
	always_comb begin
		case (ir_i.any.opcode)
			hlane_pkg::OP_R2:
				case (ir_i.r2.func)
					hlane_pkg::OP_R1:
						case (hlane_pkg::r1_e'(ir_i.r2.rb))
							hlane_pkg::OP_CNTLZ:   o_o = {11'd0, cntlz};
							hlane_pkg::OP_FABS:    o_o = {1'b0, a_i[14:0]};
							hlane_pkg::OP_FNABS:   o_o = {1'b1, a_i[14:0]};
							hlane_pkg::OP_FNEG:    o_o = {~a_i[15], a_i[14:0]};
							hlane_pkg::OP_FCLASS:  o_o = fclass;
							hlane_pkg::OP_FSIGN:
								o_o = vz ? '0 : (sgn ? hlane_pkg::FP_ONE_NEG : hlane_pkg::FP_ONE_POS);
							hlane_pkg::OP_FFINITE: o_o = flag(~xinf);
							hlane_pkg::OP_SEXTB:   o_o = {{8{a_i[7]}}, a_i[7:0]};
							default:               o_o = '0;
						endcase
					hlane_pkg::OP_ADD:     o_o = a_i + b_i; // wraps mod 2^16
					hlane_pkg::OP_SUB:     o_o = a_i - b_i;
					hlane_pkg::OP_AND:     o_o = a_i & b_i;
					hlane_pkg::OP_OR:      o_o = a_i | b_i;
					hlane_pkg::OP_XOR:     o_o = a_i ^ b_i;
					hlane_pkg::OP_CMP_EQ:  o_o = flag(a_i == b_i);
					hlane_pkg::OP_CMP_NE:  o_o = flag(a_i != b_i);
					hlane_pkg::OP_CMP_LT:  o_o = flag($signed(a_i) < $signed(b_i));
					hlane_pkg::OP_CMP_GE:  o_o = flag($signed(a_i) >= $signed(b_i));
					hlane_pkg::OP_CMP_LE:  o_o = flag($signed(a_i) <= $signed(b_i));
					hlane_pkg::OP_CMP_GT:  o_o = flag($signed(a_i) > $signed(b_i));
					hlane_pkg::OP_CMP_LTU: o_o = flag(a_i < b_i);
					hlane_pkg::OP_CMP_GEU: o_o = flag(a_i >= b_i);
					hlane_pkg::OP_CMP_LEU: o_o = flag(a_i <= b_i);
					hlane_pkg::OP_CMP_GTU: o_o = flag(a_i > b_i);
					hlane_pkg::OP_FCMP_EQ: o_o = flag(fcmp[0]);
					hlane_pkg::OP_FCMP_NE: o_o = flag(fcmp[8] | fcmp[4]); // 1 on nan
					hlane_pkg::OP_FCMP_LT: o_o = flag(fcmp[1]);
					hlane_pkg::OP_FCMP_LE: o_o = flag(fcmp[2]);
					hlane_pkg::OP_FCMP_GT: o_o = flag(fcmp[10]);
					hlane_pkg::OP_FCMP_GE: o_o = flag(fcmp[9]);
					default:               o_o = '0;
				endcase
			hlane_pkg::OP_ADDI:     o_o = a_i + imm_i;
			hlane_pkg::OP_SUBFI:    o_o = imm_i - a_i;   // reversed operands
			hlane_pkg::OP_ANDI:     o_o = a_i & imm_i;
			hlane_pkg::OP_ORI:      o_o = a_i | imm_i;
			hlane_pkg::OP_XORI:     o_o = a_i ^ imm_i;
			hlane_pkg::OP_CMP_EQI:  o_o = flag(a_i == imm_i);
			hlane_pkg::OP_CMP_NEI:  o_o = flag(a_i != imm_i);
			hlane_pkg::OP_CMP_LTI:  o_o = flag($signed(a_i) < $signed(imm_i));
			hlane_pkg::OP_CMP_GEI:  o_o = flag($signed(a_i) >= $signed(imm_i));
			hlane_pkg::OP_CMP_LEI:  o_o = flag($signed(a_i) <= $signed(imm_i));
			hlane_pkg::OP_CMP_GTI:  o_o = flag($signed(a_i) > $signed(imm_i));
			hlane_pkg::OP_CMP_LTUI: o_o = flag(a_i < imm_i);
			hlane_pkg::OP_CMP_GEUI: o_o = flag(a_i >= imm_i);
			hlane_pkg::OP_CMP_LEUI: o_o = flag(a_i <= imm_i);
			hlane_pkg::OP_CMP_GTUI: o_o = flag(a_i > imm_i);
			hlane_pkg::OP_FCMP_EQI: o_o = flag(fcmpi[0]);
			hlane_pkg::OP_FCMP_NEI: o_o = flag(fcmpi[8] | fcmpi[4]);
			hlane_pkg::OP_FCMP_LTI: o_o = flag(fcmpi[1]);
			hlane_pkg::OP_FCMP_LEI: o_o = flag(fcmpi[2]);
			hlane_pkg::OP_FCMP_GTI: o_o = flag(fcmpi[10]);
			hlane_pkg::OP_FCMP_GEI: o_o = flag(fcmpi[9]);
			default:                o_o = '0;
		endcase
	end

endmodule

// ==== rtl/fp_compare16.sv ====
`timescale 1ns/10ps

module fp_compare16 (
	input  hlane_pkg::half_value_t a_i,
	input  hlane_pkg::half_value_t b_i,
	output logic [15:0]            o_o
);

	logic        sa, sb;   // signs
	logic        za, zb;   // +/-0
	logic        sna, snb;
	logic        qna, qnb;
	logic [14:0] ma, mb;   // magnitudes
	logic        nan;      // unordered pair
	logic        both_z;
	logic        eq;
	logic        lt;

	fp_decomp16 decomp_a_inst (
		.i_i   (a_i),
		.sgn_o (sa),
		.xz_o  (),
		.vz_o  (za),
		.inf_o (),
		.xinf_o(),
		.snan_o(sna),
		.qnan_o(qna)
	);

	fp_decomp16 decomp_b_inst (
		.i_i   (b_i),
		.sgn_o (sb),
		.xz_o  (),
		.vz_o  (zb),
		.inf_o (),
		.xinf_o(),
		.snan_o(snb),
		.qnan_o(qnb)
	);

	assign ma     = a_i[14:0];
	assign mb     = b_i[14:0];
	assign nan    = sna | qna | snb | qnb;
	assign both_z = za & zb;               // +0 == -0
	assign eq     = ~nan & (both_z | (a_i == b_i));

	// sign-magnitude ordering, nan masked below
	always_comb begin
		case ({sa, sb})
			2'b10:   lt = ~both_z;    // neg < pos unless both are zero
			2'b01:   lt = 1'b0;
			2'b00:   lt = (ma < mb);
			default: lt = (ma > mb);  // both negative, bigger mag is smaller
		endcase
	end

	always_comb begin
		o_o     = '0;
		o_o[0]  = eq;
		o_o[1]  = ~nan & lt;
		o_o[2]  = ~nan & (lt | eq);
		o_o[4]  = nan;                 // unordered
		o_o[8]  = ~eq;                 // also set for nan
		o_o[9]  = ~nan & ~lt;
		o_o[10] = ~nan & ~(lt | eq);
	end

endmodule

// ==== rtl/fp_decomp16.sv ====
`timescale 1ns/10ps

module fp_decomp16 (
	input  hlane_pkg::half_value_t i_i,
	output logic                   sgn_o,
	output logic                   xz_o,   // exponent all zeros
	output logic                   vz_o,   // value is +/-0
	output logic                   inf_o,
	output logic                   xinf_o, // exponent all ones
	output logic                   snan_o,
	output logic                   qnan_o
);

	logic [4:0] expo; // biased exponent
	logic [9:0] man;  // stored mantissa, no hidden bit
	logic       mz;   // mantissa zero

	assign sgn_o = i_i[15];
	assign expo  = i_i[14:10];
	assign man   = i_i[9:0];

	assign xz_o   = (expo == 5'd0);
	assign xinf_o = &expo;
	assign mz     = (man == 10'd0);

	// zero and subnormal share exponent 0, mantissa tells them apart
	assign vz_o  = xz_o & mz;
	assign inf_o = xinf_o & mz;

	// nan kind is set by the top mantissa bit
	assign snan_o = xinf_o & ~mz & ~man[9];
	assign qnan_o = xinf_o & man[9];

endmodule

// ==== rtl/hlane_pkg.sv ====
package hlane_pkg;

	// ============================================================
	// basic lane types
	// ============================================================
	typedef logic [15:0] half_value_t; // int16 or binary16, op decides
	typedef logic [4:0] reg_idx_t;

	localparam int NREGS = 32; // register file depth

	// results of the sign op
	localparam half_value_t FP_ONE_POS = 16'h3C00; // +1.0
	localparam half_value_t FP_ONE_NEG = 16'hBC00; // -1.0

	// ============================================================
	// instruction encoding
	// ============================================================
	typedef enum logic [5:0] {
		OP_R2       = 6'd0, // two-register forms, func picks the op
		OP_ADDI     = 6'd4,
		OP_SUBFI    = 6'd5, // imm - a
		OP_ANDI     = 6'd8,
		OP_ORI      = 6'd9,
		OP_XORI     = 6'd10,
		OP_CMP_EQI  = 6'd16, OP_CMP_NEI  = 6'd17,
		OP_CMP_LTI  = 6'd18, OP_CMP_GEI  = 6'd19,
		OP_CMP_LEI  = 6'd20, OP_CMP_GTI  = 6'd21,
		OP_CMP_LTUI = 6'd22, OP_CMP_GEUI = 6'd23,
		OP_CMP_LEUI = 6'd24, OP_CMP_GTUI = 6'd25,
		OP_FCMP_EQI = 6'd32, OP_FCMP_NEI = 6'd33,
		OP_FCMP_LTI = 6'd34, OP_FCMP_LEI = 6'd35,
		OP_FCMP_GTI = 6'd36, OP_FCMP_GEI = 6'd37
	} opcode_e;

	typedef enum logic [5:0] {
		OP_R1      = 6'd1, // unary, rb field holds the r1 selector
		OP_ADD     = 6'd4,
		OP_SUB     = 6'd5,
		OP_AND     = 6'd8,
		OP_OR      = 6'd9,
		OP_XOR     = 6'd10,
		OP_CMP_EQ  = 6'd16, OP_CMP_NE  = 6'd17,
		OP_CMP_LT  = 6'd18, OP_CMP_GE  = 6'd19,
		OP_CMP_LE  = 6'd20, OP_CMP_GT  = 6'd21,
		OP_CMP_LTU = 6'd22, OP_CMP_GEU = 6'd23,
		OP_CMP_LEU = 6'd24, OP_CMP_GTU = 6'd25,
		OP_FCMP_EQ = 6'd32, OP_FCMP_NE = 6'd33,
		OP_FCMP_LT = 6'd34, OP_FCMP_LE = 6'd35,
		OP_FCMP_GT = 6'd36, OP_FCMP_GE = 6'd37
	} func_e;

	typedef enum logic [4:0] {
		OP_CNTLZ   = 5'd0,
		OP_FABS    = 5'd1,
		OP_FNABS   = 5'd2,
		OP_FNEG    = 5'd3,
		OP_FCLASS  = 5'd4,
		OP_FSIGN   = 5'd5,
		OP_FFINITE = 5'd6,
		OP_SEXTB   = 5'd7
	} r1_e;

	typedef struct packed {
		opcode_e    opcode;
		reg_idx_t   rd;
		reg_idx_t   ra;
		reg_idx_t   rb; // unary selector when func is OP_R1
		func_e      func;
		logic [4:0] pad;
	} r2_instr_t;

	typedef struct packed {
		opcode_e     opcode;
		reg_idx_t    rd;
		reg_idx_t    ra;
		half_value_t imm;
	} ri_instr_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [25:0] rest; // layout depends on opcode
	} any_instr_t;

	typedef union packed {
		r2_instr_t  r2;
		ri_instr_t  ri;
		any_instr_t any;
	} instruction_t;

	// ============================================================
	// pipeline payloads
	// ============================================================
	typedef struct packed {
		instruction_t ir;
		half_value_t  a;   // ra operand after forwarding
		half_value_t  b;   // rb operand after forwarding
		half_value_t  imm;
	} issue_t;

	typedef struct packed {
		reg_idx_t    rd;
		half_value_t value;
	} result_t;

endpackage

// ==== rtl/hlane_regfile.sv ====
`timescale 1ns/10ps

module hlane_regfile (
	input  logic                   clk_i,
	input  logic                   arst_n_i,
	// read ports, combinational
	input  hlane_pkg::reg_idx_t    ra_i,
	input  hlane_pkg::reg_idx_t    rb_i,
	output hlane_pkg::half_value_t a_o,
	output hlane_pkg::half_value_t b_o,
	// writeback from the result stage
	input  logic                   wr_i,
	input  hlane_pkg::result_t     wr_res_i,
	// external preset
	input  logic                   ld_i,
	input  hlane_pkg::reg_idx_t    ld_idx_i,
	input  hlane_pkg::half_value_t ld_data_i
);

	hlane_pkg::half_value_t regs_q [hlane_pkg::NREGS];

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < hlane_pkg::NREGS; i++) begin
				regs_q[i] <= '0;
			end
		end else begin
			if (ld_i)
				regs_q[ld_idx_i] <= ld_data_i;
			if (wr_i)
				regs_q[wr_res_i.rd] <= wr_res_i.value; // last nba wins the collision
		end
	end

	// write-through so an issue in the writeback cycle sees the new value
	assign a_o = (wr_i && (wr_res_i.rd == ra_i)) ? wr_res_i.value : regs_q[ra_i];
	assign b_o = (wr_i && (wr_res_i.rd == rb_i)) ? wr_res_i.value : regs_q[rb_i];

endmodule

// ==== rtl/hlane_top.sv ====
`timescale 1ns/10ps

module hlane_top (
	input  logic                    clk_i,
	input  logic                    arst_n_i,
	input  logic                    issue_i,   // one-cycle strobe
	input  hlane_pkg::instruction_t instr_i,
	input  logic                    ld_i,
	input  hlane_pkg::reg_idx_t     ld_idx_i,
	input  hlane_pkg::half_value_t  ld_data_i,
	output logic                    res_valid_o,
	output hlane_pkg::result_t      res_o
);

	hlane_pkg::half_value_t rf_a, rf_b;   // regfile read data
	hlane_pkg::half_value_t alu_o;
	hlane_pkg::issue_t      s1_d, s1_q;   // stage 1 payload
	logic                   s1_valid_q;
	logic                   fwd_a, fwd_b;

	hlane_regfile regfile_inst (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.ra_i     (instr_i.r2.ra),
		.rb_i     (instr_i.r2.rb),
		.a_o      (rf_a),
		.b_o      (rf_b),
		.wr_i     (res_valid_o),   // stage 2 writes back
		.wr_res_i (res_o),
		.ld_i     (ld_i),
		.ld_idx_i (ld_idx_i),
		.ld_data_i(ld_data_i)
	);

	// ============================================================
	// issue and forwarding
	// ============================================================
	// the instruction in stage 1 is one older than the incoming one
	assign fwd_a = s1_valid_q && (s1_q.ir.r2.rd == instr_i.r2.ra);
	assign fwd_b = s1_valid_q && (s1_q.ir.r2.rd == instr_i.r2.rb);

	always_comb begin
		s1_d.ir  = instr_i;
		s1_d.a   = fwd_a ? alu_o : rf_a;
		s1_d.b   = fwd_b ? alu_o : rf_b;  // rb is the unary selector for r1, harmless
		s1_d.imm = instr_i.ri.imm;
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			s1_valid_q <= 1'b0;
		else
			s1_valid_q <= issue_i;
	end

	always_ff @(posedge clk_i) begin
		if (issue_i)
			s1_q <= s1_d;
	end

	alu16 alu_inst (
		.ir_i (s1_q.ir),
		.a_i  (s1_q.a),
		.b_i  (s1_q.b),
		.imm_i(s1_q.imm),
		.o_o  (alu_o)
	);

	// ============================================================
	// result stage
	// ============================================================
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			res_valid_o <= 1'b0;
			res_o       <= '0;
		end else begin
			res_valid_o <= s1_valid_q;
			if (s1_valid_q)
				res_o <= '{rd: s1_q.ir.r2.rd, value: alu_o}; // holds last result otherwise
		end
	end

endmodule

// ==== src.f ====
rtl/hlane_pkg.sv
rtl/fp_decomp16.sv
rtl/fp_compare16.sv
rtl/alu16.sv
rtl/hlane_regfile.sv
rtl/hlane_top.sv
verif/clk_gen.sv
verif/hlane_checker.sv
verif/tb_hlane.sv

// ==== verif/clk_gen.sv ====
`timescale 1ns/10ps

module clk_gen (
	output logic clk_o,
	output logic arst_n_o
);

	localparam int HALF_NS    = 20; // 40 ns period
	localparam int RST_CYCLES = 5;

	initial begin
		clk_o = 1'b0;
		forever #(HALF_NS) clk_o = ~clk_o;
	end

	// reset held low for a few edges, released just after one
	initial begin
		arst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_o);
		arst_n_o <= 1'b1;
	end

endmodule

// ==== verif/hlane_checker.sv ====
`timescale 1ns/10ps

module hlane_checker (
	input  logic                    clk_i,
	input  logic                    arst_n_i,
	input  logic                    issue_i,
	input  hlane_pkg::instruction_t instr_i,
	input  logic                    ld_i,
	input  hlane_pkg::reg_idx_t     ld_idx_i,
	input  hlane_pkg::half_value_t  ld_data_i,
	input  logic                    res_valid_i,
	input  hlane_pkg::result_t      res_i,
	input  logic                    test_end_i, // one-cycle strobe from stimulus
	input  int                      test_num_i,
	output int                      pending_o,  // results still owed by the DUT
	output int                      pass_cnt_o,
	output int                      fail_cnt_o
);

	hlane_pkg::half_value_t model_q [hlane_pkg::NREGS]; // sequential register view
	hlane_pkg::result_t     exp_q [$];
	longint                 due_q [$];                  // cycle each result is owed
	hlane_pkg::result_t     want;
	longint                 due;
	longint                 cyc;
	int                     test_err, test_res;
	int                     pass_cnt, fail_cnt;

	// ============================================================
	// reference model
	// ============================================================
	function automatic logic is_nan(input hlane_pkg::half_value_t x);
		return (x[14:10] == 5'h1F) && (x[9:0] != 10'd0);
	endfunction

	// signed integer with the same order as the half value, both zeros map to 0
	function automatic int order_key(input hlane_pkg::half_value_t x);
		int mag;
		mag = int'(x[14:0]);
		return x[15] ? -mag : mag;
	endfunction

	// kind follows EQ NE LT LE GT GE
	function automatic logic fcmp(input hlane_pkg::half_value_t a, b, input int kind);
		logic nan, eq, lt, r;
		nan = is_nan(a) || is_nan(b);
		eq  = !nan && (order_key(a) == order_key(b));
		lt  = !nan && (order_key(a) < order_key(b));
		case (kind)
			0:       r = eq;
			1:       r = !eq;              // nan counts as not equal
			2:       r = lt;
			3:       r = lt || eq;
			4:       r = !nan && !(lt || eq);
			5:       r = !nan && !lt;
			default: r = 1'b0;
		endcase
		return r;
	endfunction

	// kind follows EQ NE LT GE LE GT LTU GEU LEU GTU
	function automatic logic icmp(input hlane_pkg::half_value_t a, b, input int kind);
		logic signed [15:0] sa, sb;
		logic               r;
		sa = a;
		sb = b;
		case (kind)
			0:       r = (a == b);
			1:       r = (a != b);
			2:       r = (sa < sb);
			3:       r = (sa >= sb);
			4:       r = (sa <= sb);
			5:       r = (sa > sb);
			6:       r = (a < b);
			7:       r = (a >= b);
			8:       r = (a <= b);
			9:       r = (a > b);
			default: r = 1'b0;
		endcase
		return r;
	endfunction

	function automatic hlane_pkg::half_value_t unary(input hlane_pkg::half_value_t a,
			input int sel);
		hlane_pkg::half_value_t r;
		logic [4:0]             e;
		logic [9:0]             m;
		int                     n;
		e = a[14:10];
		m = a[9:0];
		n = 0;
		r = '0;
		case (sel)
			0: begin
				while (n < 16 && !a[15 - n])
					n++;                       // 16 when a is zero
				r = hlane_pkg::half_value_t'(n);
			end
			1: r = a & 16'h7FFF;
			2: r = a | 16'h8000;
			3: r = a ^ 16'h8000;
			4: begin
				r[0]  = a[15] && (e == 5'h1F) && (m == 10'd0);
				r[1]  = a[15];
				r[2]  = a[15] && (e == 5'd0) && (m != 10'd0);
				r[3]  = a[15] && (a[14:0] == 15'd0);
				r[4]  = !a[15] && (a[14:0] == 15'd0);
				r[5]  = !a[15] && (e == 5'd0) && (m != 10'd0);
				r[6]  = !a[15];
				r[7]  = !a[15] && (e == 5'h1F) && (m == 10'd0);
				r[8]  = (e == 5'h1F) && (m != 10'd0) && !m[9]; // signalling
				r[9]  = (e == 5'h1F) && m[9];
				r[15] = a[15];
			end
			5: begin
				if (a[14:0] == 15'd0)
					r = '0;
				else
					r = a[15] ? hlane_pkg::FP_ONE_NEG : hlane_pkg::FP_ONE_POS;
			end
			6: r = {15'd0, e != 5'h1F};
			7: r = a[7] ? (16'hFF00 | {8'h00, a[7:0]}) : {8'h00, a[7:0]};
			default: r = '0;
		endcase
		return r;
	endfunction

	function automatic hlane_pkg::half_value_t ref_alu(input hlane_pkg::instruction_t ir,
			input hlane_pkg::half_value_t a, b);
		hlane_pkg::half_value_t imm, r;
		int                     code;
		imm = ir.ri.imm;
		r   = '0;
		if (ir.any.opcode == hlane_pkg::OP_R2) begin
			code = int'(ir.r2.func);
			case (ir.r2.func)
				hlane_pkg::OP_R1:  r = unary(a, int'(ir.r2.rb)); // rb holds the selector
				hlane_pkg::OP_ADD: r = a + b;
				hlane_pkg::OP_SUB: r = a - b;
				hlane_pkg::OP_AND: r = a & b;
				hlane_pkg::OP_OR:  r = a | b;
				hlane_pkg::OP_XOR: r = a ^ b;
				default: begin
					if (code >= 16 && code <= 25)
						r = {15'd0, icmp(a, b, code - 16)};
					else if (code >= 32 && code <= 37)
						r = {15'd0, fcmp(a, b, code - 32)};
				end
			endcase
		end else begin
			code = int'(ir.any.opcode);
			case (ir.any.opcode)
				hlane_pkg::OP_ADDI:  r = a + imm;
				hlane_pkg::OP_SUBFI: r = imm - a;
				hlane_pkg::OP_ANDI:  r = a & imm;
				hlane_pkg::OP_ORI:   r = a | imm;
				hlane_pkg::OP_XORI:  r = a ^ imm;
				default: begin
					if (code >= 16 && code <= 25)
						r = {15'd0, icmp(a, imm, code - 16)};
					else if (code >= 32 && code <= 37)
						r = {15'd0, fcmp(a, imm, code - 32)};
				end
			endcase
		end
		return r;
	endfunction

	// ============================================================
	// monitor and compare
	// ============================================================
	always @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < hlane_pkg::NREGS; i++)
				model_q[i] = '0;
			exp_q.delete();
			due_q.delete();
			cyc      = 0;
			test_err = 0;
			test_res = 0;
			pass_cnt = 0;
			fail_cnt = 0;
		end else begin
			cyc++;
			if (res_valid_i) begin
				if (exp_q.size() == 0) begin
					$display("unexpected result for r%0d at %0t, no instruction in flight",
						res_i.rd, $time);
					test_err++;
				end else begin
					want = exp_q.pop_front();
					due  = due_q.pop_front();
					test_res++;
					if (due != cyc) begin
						$display("result for r%0d came at cycle %0d but was due at cycle %0d",
							want.rd, cyc, due);
						test_err++;
					end
					if (res_i != want) begin
						$display("[ERROR] %0t: rd %0d expected %04h, got rd %0d value %04h",
							$time, want.rd, want.value, res_i.rd, res_i.value);
						test_err++;
					end
				end
			end
			if (ld_i)
				model_q[ld_idx_i] = ld_data_i;
			if (issue_i) begin
				want.rd    = instr_i.r2.rd;
				want.value = ref_alu(instr_i, model_q[instr_i.r2.ra], model_q[instr_i.r2.rb]);
				model_q[want.rd] = want.value; // next issue sees it at once
				exp_q.push_back(want);
				due_q.push_back(cyc + 2);      // fixed two-cycle latency
			end
			if (test_end_i) begin
				if (test_err == 0) begin
					$display("test %0d passed, %0d results", test_num_i, test_res);
					pass_cnt++;
				end else begin
					$display("test %0d has %0d errors in %0d results",
						test_num_i, test_err, test_res);
					fail_cnt++;
				end
				test_err = 0;
				test_res = 0;
			end
		end
		pending_o  <= exp_q.size();
		pass_cnt_o <= pass_cnt;
		fail_cnt_o <= fail_cnt;
	end

endmodule

// ==== verif/tb_hlane.sv ====
`timescale 1ns/10ps

module tb_hlane;

	localparam int N_T1    = 3;  // instructions per test
	localparam int N_T2    = 20;
	localparam int N_T3    = 70;
	localparam int N_T4    = 72;
	localparam int N_T5    = 80;
	localparam int N_T6    = 24;
	localparam int N_INSTR = N_T1 + N_T2 + N_T3 + N_T4 + N_T5 + N_T6;
	localparam int N_TESTS = 6;
	localparam int LIMIT   = N_INSTR * 3 + 100;

	logic                    clk, arst_n;
	logic                    issue, ld, res_valid;
	hlane_pkg::instruction_t instr;
	hlane_pkg::reg_idx_t     ld_idx;
	hlane_pkg::half_value_t  ld_data;
	hlane_pkg::result_t      res;
	logic                    test_end;
	int                      test_num, pending, pass_cnt, fail_cnt;
	int                      seed;
	int                      cycles;

	// +-0, +-inf, +-subnormal, qnan, snan, 1.0, -2.0
	hlane_pkg::half_value_t fp_vals [10] = '{16'h0000, 16'h8000, 16'h7C00, 16'hFC00,
		16'h0001, 16'h8200, 16'h7E00, 16'h7C01, 16'h3C00, 16'hC000};

	clk_gen clk_gen_inst (.clk_o(clk), .arst_n_o(arst_n));

	hlane_top hlane_top_inst (
		.clk_i      (clk),
		.arst_n_i   (arst_n),
		.issue_i    (issue),
		.instr_i    (instr),
		.ld_i       (ld),
		.ld_idx_i   (ld_idx),
		.ld_data_i  (ld_data),
		.res_valid_o(res_valid),
		.res_o      (res)
	);

	hlane_checker checker_inst (
		.clk_i(clk), .arst_n_i(arst_n),
		.issue_i(issue), .instr_i(instr),
		.ld_i(ld), .ld_idx_i(ld_idx), .ld_data_i(ld_data),
		.res_valid_i(res_valid), .res_i(res),
		.test_end_i(test_end), .test_num_i(test_num),
		.pending_o(pending), .pass_cnt_o(pass_cnt), .fail_cnt_o(fail_cnt)
	);

	// ============================================================
	// instruction builders and drivers
	// ============================================================
	function automatic hlane_pkg::instruction_t reg_form(input hlane_pkg::func_e f,
			input int rd, ra, rb);
		hlane_pkg::instruction_t ir;
		ir           = '0;
		ir.r2.opcode = hlane_pkg::OP_R2;
		ir.r2.func   = f;
		ir.r2.rd     = hlane_pkg::reg_idx_t'(rd);
		ir.r2.ra     = hlane_pkg::reg_idx_t'(ra);
		ir.r2.rb     = hlane_pkg::reg_idx_t'(rb);
		return ir;
	endfunction

	function automatic hlane_pkg::instruction_t imm_form(input hlane_pkg::opcode_e op,
			input int rd, ra, input hlane_pkg::half_value_t imm);
		hlane_pkg::instruction_t ir;
		ir.ri.opcode = op;
		ir.ri.rd     = hlane_pkg::reg_idx_t'(rd);
		ir.ri.ra     = hlane_pkg::reg_idx_t'(ra);
		ir.ri.imm    = imm;
		return ir;
	endfunction

	function automatic hlane_pkg::instruction_t unary_form(input int sel, rd, ra);
		return reg_form(hlane_pkg::OP_R1, rd, ra, sel); // selector rides in rb
	endfunction

	task automatic load_reg(input int idx, input hlane_pkg::half_value_t val);
		@(posedge clk);
		ld      <= 1'b1;
		ld_idx  <= hlane_pkg::reg_idx_t'(idx);
		ld_data <= val;
		issue   <= 1'b0;
	endtask

	task automatic issue_instr(input hlane_pkg::instruction_t ir);
		@(posedge clk);
		issue <= 1'b1;
		instr <= ir;
		ld    <= 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			issue <= 1'b0;
			ld    <= 1'b0;
		end
	endtask

	// let the pipe drain, then tell the checker the test is over
	task automatic finish_test(input int num);
		idle(1);
		@(posedge clk);
		while (pending != 0)
			@(posedge clk);
		test_num <= num;
		test_end <= 1'b1;
		@(posedge clk);
		test_end <= 1'b0;
	endtask

	// ============================================================
	// tests
	// ============================================================
	task automatic run_latency_test();
		idle(4); // checker flags any result here
		load_reg(1, 16'h0005);
		load_reg(2, 16'h0007);
		issue_instr(reg_form(hlane_pkg::OP_ADD, 3, 1, 2));
		issue_instr(reg_form(hlane_pkg::OP_SUB, 4, 1, 2)); // wraps to fffe
		issue_instr(reg_form(hlane_pkg::OP_XOR, 5, 1, 2));
		finish_test(1);
	endtask

	task automatic run_reg_alu_test();
		hlane_pkg::func_e ops [5] = '{hlane_pkg::OP_ADD, hlane_pkg::OP_SUB,
			hlane_pkg::OP_AND, hlane_pkg::OP_OR, hlane_pkg::OP_XOR};
		for (int r = 1; r <= 8; r++)
			load_reg(r, hlane_pkg::half_value_t'($random(seed)));
		for (int i = 0; i < N_T2; i++)
			issue_instr(reg_form(ops[i % 5], 9 + i % 8, 1 + ({$random(seed)} % 8),
				1 + ({$random(seed)} % 8)));
		finish_test(2);
	endtask

	task automatic run_imm_int_cmp_test();
		hlane_pkg::opcode_e ops [5] = '{hlane_pkg::OP_ADDI, hlane_pkg::OP_SUBFI,
			hlane_pkg::OP_ANDI, hlane_pkg::OP_ORI, hlane_pkg::OP_XORI};
		int ra [3] = '{1, 1, 2};
		int rb [3] = '{2, 3, 6};
		hlane_pkg::half_value_t iv [3] = '{16'h8000, 16'h7FFF, 16'h7FFF};
		load_reg(1, 16'h7FFF);
		load_reg(2, 16'h8000);
		load_reg(3, 16'h7FFF); // equal to r1
		load_reg(4, hlane_pkg::half_value_t'($random(seed)));
		load_reg(5, 16'h0000);
		load_reg(6, 16'hFFFF);
		for (int k = 0; k < 5; k++) begin
			issue_instr(imm_form(ops[k], 10 + k, 4, hlane_pkg::half_value_t'($random(seed))));
			issue_instr(imm_form(ops[k], 15 + k, 1, 16'h0001)); // 7fff boundary
		end
		for (int c = 0; c < 10; c++)
			for (int p = 0; p < 3; p++)
				issue_instr(reg_form(hlane_pkg::func_e'(16 + c), 20, ra[p], rb[p]));
		for (int c = 0; c < 10; c++)
			for (int p = 0; p < 3; p++)
				issue_instr(imm_form(hlane_pkg::opcode_e'(16 + c), 21, p + 1, iv[p]));
		finish_test(3);
	endtask

	task automatic run_fp_cmp_test();
		int pa [8] = '{1, 3, 4, 5, 6, 7, 8, 9};
		int pb [8] = '{2, 9, 10, 1, 5, 9, 8, 10};
		int ia [4] = '{1, 9, 3, 6};
		hlane_pkg::half_value_t iv [4] = '{16'h8000, 16'h7E00, 16'h7C00, 16'h0001};
		for (int r = 0; r < 10; r++)
			load_reg(r + 1, fp_vals[r]);
		for (int c = 0; c < 6; c++)
			for (int p = 0; p < 8; p++)
				issue_instr(reg_form(hlane_pkg::func_e'(32 + c), 20, pa[p], pb[p]));
		for (int c = 0; c < 6; c++)
			for (int p = 0; p < 4; p++)
				issue_instr(imm_form(hlane_pkg::opcode_e'(32 + c), 21, ia[p], iv[p]));
		finish_test(4);
	endtask

	task automatic run_unary_test();
		for (int r = 0; r < 9; r++)
			load_reg(r + 1, fp_vals[r]);
		// random upper bits, low byte negative for sextb
		load_reg(10, hlane_pkg::half_value_t'($random(seed)) | 16'h0080);
		for (int s = 0; s < 8; s++)
			for (int r = 1; r <= 10; r++)
				issue_instr(unary_form(s, 20 + s, r));
		finish_test(5);
	endtask

	// each op reads the previous rd (forward), some also the one before it (write-through)
	task automatic run_chain_test();
		int prev, prev2, rd;
		prev  = 20;
		prev2 = 20;
		load_reg(20, hlane_pkg::half_value_t'($random(seed)));
		for (int i = 0; i < N_T6; i++) begin
			rd = 21 + i % 4;
			case (i % 6)
				0: issue_instr(imm_form(hlane_pkg::OP_ADDI, rd, prev,
					hlane_pkg::half_value_t'($random(seed))));
				1: issue_instr(reg_form(hlane_pkg::OP_ADD, rd, prev, prev));
				2: issue_instr(imm_form(hlane_pkg::OP_XORI, rd, prev,
					hlane_pkg::half_value_t'($random(seed))));
				3: issue_instr(imm_form(hlane_pkg::OP_SUBFI, rd, prev,
					hlane_pkg::half_value_t'($random(seed))));
				4: issue_instr(unary_form(int'(hlane_pkg::OP_FNEG), rd, prev));
				default: issue_instr(reg_form(hlane_pkg::OP_SUB, rd, prev2, prev));
			endcase
			prev2 = prev;
			prev  = rd;
		end
		finish_test(6);
	endtask

	// ============================================================
	// main sequence and watchdog
	// ============================================================
	initial begin
		seed     = 19;
		issue    = 1'b0;
		instr    = '0;
		ld       = 1'b0;
		ld_idx   = '0;
		ld_data  = '0;
		test_end = 1'b0;
		test_num = 0;
		@(posedge arst_n);
		run_latency_test();
		run_reg_alu_test();
		run_imm_int_cmp_test();
		run_fp_cmp_test();
		run_unary_test();
		run_chain_test();
		repeat (2) @(posedge clk); // counts settle
		$display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && pass_cnt == N_TESTS)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, %0d results never arrived", cycles, pending);
		$display("Test failed");
		$finish;
	end

endmodule
